/* fifo_cdc_top.f */
rtl/fifo_pkg.sv
rtl/fifo_gray_counter.sv
rtl/fifo_sync.sv
rtl/fifo_dp_ram.sv
rtl/fifo_async.sv
rtl/fifo_cdc_top.sv
test/fifo_cdc_assertions.sv
test/fifo_cdc_tb.sv

/* test/fifo_cdc_tb.sv */
`timescale 1ns/1ps

module fifo_cdc_tb;

   import fifo_pkg::*;

   localparam int TBL_LEN = 96;
   localparam int CYCLE_LIMIT = 40 * TBL_LEN;
   localparam logic [31:0] SEED = 32'd78;

   logic         w_clk_i = 1'b0;
   logic         r_clk_i = 1'b0;
   logic         rst_n_i;
   logic         w_en_i;
   w_data_t      w_data_i;
   logic         r_en_i;
   r_data_t      r_data_o;
   fifo_status_t w_status_o;
   fifo_status_t r_status_o;

   // stimulus table, byte value and idle gap before it
   w_data_t      tbl_data [TBL_LEN];
   int           tbl_gap  [TBL_LEN];
   logic [31:0]  rnd_state = SEED;
   w_data_t      model_q [$];
   int           acc_bytes = 0;
   int           rx_words = 0;
   int           word_errs = 0;
   int           status_errs = 0;
   int           other_errs = 0;
   int           cycles = 0;
   bit           wr_done;

   fifo_cdc_top u_dut (.*);

   initial forever #4 w_clk_i = ~w_clk_i;
   initial forever #7 r_clk_i = ~r_clk_i;

   always @(posedge w_clk_i) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run stopped, cycle limit of %0d write clocks reached", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rnd_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rnd_state = x;
      return x;
   endfunction

   // flag rule: empty below one local access, full above capacity minus one
   function automatic fifo_status_t expect_status(int lvl, int incr);
      fifo_status_t s;
      s.empty = (lvl < incr);
      s.full  = (lvl > FIFO_BYTES - incr);
      s.level = level_t'(lvl);
      return s;
   endfunction

   task automatic check_word(string name, r_data_t got, r_data_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         word_errs++;
      end
   endtask

   task automatic check_status(string name, fifo_status_t got, fifo_status_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         status_errs++;
      end
   endtask

   // called on a falling write edge, returns on the next one
   task automatic write_byte(w_data_t d);
      w_en_i   = 1'b1;
      w_data_i = d;
      if (!w_status_o.full) begin
         model_q.push_back(d);
         acc_bytes++;
      end
      @(negedge w_clk_i);
      w_en_i = 1'b0;
   endtask

   task automatic read_word();
      r_data_t exp;
      r_en_i = 1'b1;
      @(negedge r_clk_i);
      r_en_i = 1'b0;
      if (model_q.size() < 4) begin
         $display("word read but the model holds fewer than four bytes");
         other_errs++;
      end else begin
         // little-endian packing, first byte in the low lane
         for (int i = 0; i < 4; i++) begin
            exp[i*8 +: 8] = model_q.pop_front();
         end
         check_word("r_data_o", r_data_o, exp);
         rx_words++;
      end
   endtask

   // read whenever data shows until the writer is done and the read side stays empty
   task automatic drain();
      int idle;
      idle = 0;
      while (!(wr_done && idle >= 10)) begin
         @(negedge r_clk_i);
         if (!r_status_o.empty) begin
            read_word();
            idle = 0;
         end else if (wr_done) begin
            idle++;
         end
      end
   endtask

   task automatic settle_and_check();
      int lvl;
      repeat (10) @(negedge r_clk_i);
      lvl = acc_bytes - 4 * rx_words;
      check_status("w_status_o", w_status_o, expect_status(lvl, 1));
      check_status("r_status_o", r_status_o, expect_status(lvl, 4));
   endtask

   initial begin
      int lvl;
      int acc_before;
      rst_n_i  = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      wr_done  = 1'b0;
      for (int i = 0; i < TBL_LEN; i++) begin
         tbl_data[i] = w_data_t'(xorshift());
         tbl_gap[i]  = xorshift() % 4;
      end
      repeat (5) @(negedge w_clk_i);
      rst_n_i = 1'b1;

      @(negedge r_clk_i);
      check_status("w_status_o", w_status_o, expect_status(0, 1));
      check_status("r_status_o", r_status_o, expect_status(0, 4));
      check_word("r_data_o", r_data_o, '0);

      // reads while empty must be ignored
      r_en_i = 1'b1;
      repeat (5) begin
         @(negedge r_clk_i);
         check_word("r_data_o", r_data_o, '0);
         check_status("r_status_o", r_status_o, expect_status(0, 4));
      end
      r_en_i = 1'b0;
      @(negedge w_clk_i);
      repeat (3) write_byte(w_data_t'(xorshift()));
      settle_and_check();

      // table stream against a reader that reads whenever it can
      fork
         begin
            @(negedge w_clk_i);
            for (int i = 0; i < TBL_LEN; i++) begin
               repeat (tbl_gap[i]) @(negedge w_clk_i);
               write_byte(tbl_data[i]);
            end
            wr_done = 1'b1;
         end
         drain();
      join
      if (rx_words != acc_bytes / 4) begin
         $display("error rx_words: got %h expected %h", rx_words, acc_bytes / 4);
         other_errs++;
      end
      settle_and_check();

      // reader idle, offer more than fits
      lvl        = acc_bytes - 4 * rx_words;
      acc_before = acc_bytes;
      @(negedge w_clk_i);
      repeat (70) write_byte(w_data_t'(xorshift()));
      if (acc_bytes - acc_before != FIFO_BYTES - lvl) begin
         $display("error accepted bytes: got %h expected %h",
                  acc_bytes - acc_before, FIFO_BYTES - lvl);
         other_errs++;
      end
      check_status("w_status_o", w_status_o, expect_status(FIFO_BYTES, 1));
      settle_and_check();
      drain();
      settle_and_check();

      $display("errors: word %0d status %0d other %0d", word_errs, status_errs, other_errs);
      if (word_errs + status_errs + other_errs == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* test/fifo_cdc_assertions.sv */
`timescale 1ns/1ps

module fifo_cdc_assertions (
   input logic                   w_clk_i,
   input logic                   r_clk_i,
   input logic                   rst_n_i,
   input logic                   mem_w_en_o,
   input logic                   mem_r_en_o,
   input fifo_pkg::fifo_status_t w_status_o,
   input fifo_pkg::fifo_status_t r_status_o,
   input fifo_pkg::w_ptr_t       w_gray,
   input fifo_pkg::r_ptr_t       r_gray,
   input fifo_pkg::w_ptr_t       w_bin,
   input fifo_pkg::r_ptr_t       r_bin
);

   import fifo_pkg::*;

   // occupancy from the live pointers of both domains, no synchronizer delay
   level_t true_level;

   assign true_level = w_bin - {r_bin, {RATIO_W{1'b0}}};

   a_no_write_full : assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
      mem_w_en_o |-> true_level < level_t'(FIFO_BYTES))
      else $error("memory written while full");

   a_no_read_empty : assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
      mem_r_en_o |-> true_level >= R_INCR)
      else $error("memory read while empty");

   // gray pointers may move by one bit at most
   a_w_gray_step : assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
      $countones(w_gray ^ $past(w_gray)) <= 1) else $error("write gray pointer jumped");

   a_r_gray_step : assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
      $countones(r_gray ^ $past(r_gray)) <= 1) else $error("read gray pointer jumped");

   a_w_level_max : assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
      w_status_o.level <= level_t'(FIFO_BYTES)) else $error("write level above capacity");

   a_r_level_max : assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
      r_status_o.level <= level_t'(FIFO_BYTES)) else $error("read level above capacity");

endmodule

bind fifo_async fifo_cdc_assertions u_assert (
   .w_clk_i    (w_clk_i),
   .r_clk_i    (r_clk_i),
   .rst_n_i    (rst_n_i),
   .mem_w_en_o (mem_w_en_o),
   .mem_r_en_o (mem_r_en_o),
   .w_status_o (w_status_o),
   .r_status_o (r_status_o),
   .w_gray     (w_gray),
   .r_gray     (r_gray),
   .w_bin      (w_bin),
   .r_bin      (r_bin)
);

/* rtl/fifo_cdc_top.sv */
`timescale 1ns/1ps

module fifo_cdc_top (
   input  logic                   rst_n_i,
   // write domain
   input  logic                   w_clk_i,
   input  logic                   w_en_i,
   input  fifo_pkg::w_data_t      w_data_i,
   output fifo_pkg::fifo_status_t w_status_o,
   // read domain
   input  logic                   r_clk_i,
   input  logic                   r_en_i,
   output fifo_pkg::r_data_t      r_data_o,
   output fifo_pkg::fifo_status_t r_status_o
);

   import fifo_pkg::*;

   logic                mem_w_en;
   logic [W_ADDR_W-1:0] mem_w_addr;
   w_data_t             mem_w_data;
   logic                mem_r_en;
   logic [R_ADDR_W-1:0] mem_r_addr;
   r_data_t             mem_r_data;

   // stage one: pointers and flags
   fifo_async u_ctrl (
      .w_clk_i      (w_clk_i),
      .r_clk_i      (r_clk_i),
      .rst_n_i      (rst_n_i),
      .w_en_i       (w_en_i),
      .w_data_i     (w_data_i),
      .r_en_i       (r_en_i),
      .w_status_o   (w_status_o),
      .r_status_o   (r_status_o),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr)
   );

   // stage two: storage with registered read
   fifo_dp_ram u_ram (
      .w_clk_i  (w_clk_i),
      .w_en_i   (mem_w_en),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_clk_i  (r_clk_i),
      .rst_n_i  (rst_n_i),
      .r_en_i   (mem_r_en),
      .r_addr_i (mem_r_addr),
      .r_data_o (mem_r_data)
   );

   assign r_data_o = mem_r_data;

endmodule

/* rtl/fifo_async.sv */
`timescale 1ns/1ps

module fifo_async (
   input  logic                          w_clk_i,
   input  logic                          r_clk_i,
   input  logic                          rst_n_i,
   // handshake
   input  logic                          w_en_i,
   input  fifo_pkg::w_data_t             w_data_i,
   input  logic                          r_en_i,
   // status per domain
   output fifo_pkg::fifo_status_t        w_status_o,
   output fifo_pkg::fifo_status_t        r_status_o,
   // memory port
   output logic                          mem_w_en_o,
   output logic [fifo_pkg::W_ADDR_W-1:0] mem_w_addr_o,
   output fifo_pkg::w_data_t             mem_w_data_o,
   output logic                          mem_r_en_o,
   output logic [fifo_pkg::R_ADDR_W-1:0] mem_r_addr_o
);

   import fifo_pkg::*;

   logic   w_en_int;
   logic   r_en_int;

   // own pointers, binary and gray
   w_ptr_t w_bin;
   w_ptr_t w_gray;
   r_ptr_t r_bin;
   r_ptr_t r_gray;

   // pointers seen from the other domain
   w_ptr_t r_wgray;
   w_ptr_t r_wbin;
   r_ptr_t w_rgray;
   r_ptr_t w_rbin;

   level_t w_level;
   level_t r_level;

   // accesses are gated by the local flag only
   assign w_en_int = w_en_i & ~w_status_o.full;
   assign r_en_int = r_en_i & ~r_status_o.empty;

   fifo_gray_counter #(
      .ptr_t (w_ptr_t)
   ) u_w_ptr (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (w_en_int),
      .bin_o   (w_bin),
      .gray_o  (w_gray)
   );

   fifo_gray_counter #(
      .ptr_t (r_ptr_t)
   ) u_r_ptr (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (r_en_int),
      .bin_o   (r_bin),
      .gray_o  (r_gray)
   );

   // write pointer into the read domain
   fifo_sync #(
      .T (w_ptr_t)
   ) u_sync_w2r (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .d_i     (w_gray),
      .q_o     (r_wgray)
   );

   // read pointer into the write domain
   fifo_sync #(
      .T (r_ptr_t)
   ) u_sync_r2w (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .d_i     (r_gray),
      .q_o     (w_rgray)
   );

   // gray to binary, msb first
   always_comb begin
      r_wbin[W_ADDR_W] = r_wgray[W_ADDR_W];
      for (int i = W_ADDR_W - 1; i >= 0; i--) begin
         r_wbin[i] = r_wbin[i+1] ^ r_wgray[i];
      end
   end

   always_comb begin
      w_rbin[R_ADDR_W] = w_rgray[R_ADDR_W];
      for (int i = R_ADDR_W - 1; i >= 0; i--) begin
         w_rbin[i] = w_rbin[i+1] ^ w_rgray[i];
      end
   end

   // read pointers count words, shift up to bytes before subtracting
   assign w_level = w_bin - {w_rbin, {RATIO_W{1'b0}}};
   assign r_level = r_wbin - {r_bin, {RATIO_W{1'b0}}};

   // flags are relative to one access of the local side
   assign w_status_o.empty = (w_level < W_INCR);
   assign w_status_o.full  = (w_level > level_t'(FIFO_BYTES) - W_INCR);
   assign w_status_o.level = w_level;

   assign r_status_o.empty = (r_level < R_INCR);
   assign r_status_o.full  = (r_level > level_t'(FIFO_BYTES) - R_INCR);
   assign r_status_o.level = r_level;

   assign mem_w_en_o   = w_en_int;
   assign mem_w_addr_o = w_bin[W_ADDR_W-1:0];
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = r_en_int;
   assign mem_r_addr_o = r_bin[R_ADDR_W-1:0];

endmodule

/* rtl/fifo_dp_ram.sv */
`timescale 1ns/1ps

module fifo_dp_ram (
   // write port, one byte per access
   input  logic                          w_clk_i,
   input  logic                          w_en_i,
   input  logic [fifo_pkg::W_ADDR_W-1:0] w_addr_i,
   input  fifo_pkg::w_data_t             w_data_i,
   // read port, one word per access
   input  logic                          r_clk_i,
   input  logic                          rst_n_i,
   input  logic                          r_en_i,
   input  logic [fifo_pkg::R_ADDR_W-1:0] r_addr_i,
   output fifo_pkg::r_data_t             r_data_o
);

   import fifo_pkg::*;

   r_data_t                 mem_q [2**R_ADDR_W];
   logic    [R_ADDR_W-1:0]  w_word;
   logic    [RATIO_W-1:0]   w_lane;

   // low address bits pick the byte lane, little-endian
   assign w_word = w_addr_i[W_ADDR_W-1:RATIO_W];
   assign w_lane = w_addr_i[RATIO_W-1:0];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem_q[w_word][w_lane*W_DATA_W +: W_DATA_W] <= w_data_i;
      end
   end

   // registered read, holds between accepted reads
   always_ff @(posedge r_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_data_o <= '0;
      end else if (r_en_i) begin
         r_data_o <= mem_q[r_addr_i];
      end
   end

endmodule

/* rtl/fifo_sync.sv */
`timescale 1ns/1ps

module fifo_sync #(
   parameter type T = fifo_pkg::r_ptr_t
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  T     d_i,
   output T     q_o
);

   // first stage may go metastable
   T meta_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         meta_q <= '0;
         q_o    <= '0;
      end else begin
         meta_q <= d_i;
         q_o    <= meta_q;
      end
   end

endmodule

/* rtl/fifo_gray_counter.sv */
`timescale 1ns/1ps

module fifo_gray_counter #(
   parameter type ptr_t = fifo_pkg::w_ptr_t
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic en_i,
   output ptr_t bin_o,
   output ptr_t gray_o
);

   ptr_t bin_next;

   assign bin_next = bin_o + 1'b1;

   // gray is registered from the next binary value so both outputs move together
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bin_o  <= '0;
         gray_o <= '0;
      end else if (en_i) begin
         bin_o  <= bin_next;
         gray_o <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

/* rtl/fifo_pkg.sv */
package fifo_pkg;

   // byte address space seen by the narrow (write) side
   localparam int ADDR_W = 6;
   // log2 of read width over write width
   localparam int RATIO_W = 2;

   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = W_DATA_W << RATIO_W;

   localparam int W_ADDR_W = ADDR_W;
   localparam int R_ADDR_W = ADDR_W - RATIO_W;

   // capacity in bytes
   localparam int FIFO_BYTES = 1 << ADDR_W;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;

   // pointers carry one extra wrap bit above the address
   typedef logic [W_ADDR_W:0] w_ptr_t;
   typedef logic [R_ADDR_W:0] r_ptr_t;

   // fill level in bytes, 0 to FIFO_BYTES
   typedef logic [ADDR_W:0] level_t;

   // pointer step of each side, in bytes
   localparam level_t W_INCR = level_t'(1);
   localparam level_t R_INCR = level_t'(1 << RATIO_W);

   typedef struct packed {
      logic   empty;
      logic   full;
      level_t level;
   } fifo_status_t;

endpackage
